/* Bender.yml */
package:
  name: tx_bd

sources:
  - src/tx_bd_pkg.sv
  - src/tx_bd_fmt_pkg.sv
  - src/dp_ram.sv
  - src/sn_fifo.sv
  - src/bd_fetch_ctrl.sv
  - src/rd_cmd_split.sv
  - src/kernel_bd_build.sv
  - src/tx_bd_top.sv
  - target: test
    files:
      - bench/tx_bd_props.sv
      - bench/tb_tx_bd.sv

/* bench/tb_tx_bd.sv */
// tx descriptor handler testbench
`timescale 1ns/10ps
`default_nettype none

module tb_tx_bd;

    localparam int n_desc     = 40;
    localparam int max_cycles = 200 * n_desc + 1000;

    logic clk_sys;
    logic rst;
    logic desc_rd;
    tx_bd_fmt_pkg::desc_t desc_data;
    logic desc_empty;
    logic rd_cmd_wr;
    logic rd_cmd_sod;
    logic rd_cmd_eod;
    tx_bd_pkg::sn_t rd_cmd_sn;
    tx_bd_pkg::chunk_len_t rd_cmd_len;
    tx_bd_pkg::addr_t rd_cmd_addr;
    tx_bd_pkg::acc_type_t rd_cmd_acc_type;
    tx_bd_pkg::ve_info_t rd_cmd_ve_info;
    logic rd_cmd_ff;
    logic hacc_wr;
    tx_bd_pkg::sn_t hacc_waddr;
    tx_bd_pkg::hacc_t hacc_wdata;
    logic rsp_wr;
    tx_bd_pkg::sn_t rsp_sn;
    logic kernel_afull;
    logic kernel_bd_wen;
    tx_bd_fmt_pkg::kbd_t kernel_bd_data;

    integer seed;
    int errors = 0;
    int checks = 0;
    int errs_at_start = 0;
    int cycles = 0;
    int desc_reads = 0;
    int cmd_count = 0;
    int eod_count = 0;
    int rec_count = 0;
    logic pop_pending = 1'b0;
    logic drive_random = 1'b0;
    logic rsp_hold = 1'b0;
    logic ff_hold = 1'b0;
    tx_bd_pkg::sn_t model_sn = '0;   // next serial number in the model

    tx_bd_fmt_pkg::desc_t desc_pool [n_desc];
    tx_bd_fmt_pkg::desc_t desc_q [$];      // descriptor FIFO contents
    logic [143:0] exp_cmd_q [$];           // {sod, eod, sn, len, addr, acc, ve}
    tx_bd_pkg::sn_t rsp_pend_q [$];
    int rsp_due_q [$];
    tx_bd_pkg::sn_t rec_q [$];             // responses in push order
    tx_bd_fmt_pkg::bd_entry_t exp_bd [512];
    tx_bd_pkg::hacc_t hacc_model [512];

    tx_bd_top #(.max_inflight(4), .rsp_depth(512), .rsp_afull_level(450)) dut_i (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    task automatic check_value(input string what, input logic [319:0] expected,
                               input logic [319:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %0t ns %s: expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s finished with %0d errors", name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    task automatic make_stimulus();
        logic [31:0] len;
        for (int i = 0; i < n_desc; i++) begin
            len = 1 + ($unsigned($random(seed)) % 16384);
            desc_pool[i][215:208] = $random(seed);
            desc_pool[i][207:192] = $random(seed);
            desc_pool[i][191:160] = $random(seed);
            desc_pool[i][159:128] = len;
            desc_pool[i][127:96]  = $random(seed);
            desc_pool[i][95:64]   = $random(seed);
            desc_pool[i][63:32]   = $random(seed);
            desc_pool[i][31:0]    = $random(seed);
        end
        for (int a = 0; a < 512; a++) begin
            hacc_model[a][87:64] = $random(seed);
            hacc_model[a][63:32] = $random(seed);
            hacc_model[a][31:0]  = $random(seed);
        end
    endtask

    task automatic load_descs(input int first, input int count);
        @(negedge clk_sys);
        #1;
        for (int i = 0; i < count; i++) begin
            desc_q.push_back(desc_pool[first + i]);
        end
    endtask

    // commands and bd entry from the field layout
    task automatic expect_descriptor(input tx_bd_fmt_pkg::desc_t d);
        logic [31:0] len;
        logic [12:0] clen;
        int n;
        len = d[159:128];
        n = (len + 4095) / 4096;
        for (int i = 0; i < n; i++) begin
            clen = (i == n - 1) ? 13'(len - 4096 * (n - 1)) : 13'd4096;
            exp_cmd_q.push_back({i == 0, i == n - 1, model_sn, clen,
                                 d[63:0] + 64'(4096 * i), d[215:208], d[207:160]});
        end
        exp_bd[model_sn] = {len, d[207:160], d[127:64], d[63:0]};
        model_sn = model_sn + 1'b1;
    endtask

    task automatic take_descriptor();
        desc_reads++;
        if (desc_q.size() == 0) begin
            errors++;
            $display("descriptor read at %0t ns while the descriptor FIFO was empty", $time);
        end else begin
            expect_descriptor(desc_q[0]);
            pop_pending = 1'b1;
        end
    endtask

    task automatic check_command();
        logic [143:0] exp;
        cmd_count++;
        if (exp_cmd_q.size() == 0) begin
            errors++;
            $display("read command at %0t ns with no command expected", $time);
        end else begin
            exp = exp_cmd_q.pop_front();
            check_value("read command", exp, {rd_cmd_sod, rd_cmd_eod, rd_cmd_sn, rd_cmd_len,
                        rd_cmd_addr, rd_cmd_acc_type, rd_cmd_ve_info});
            if (exp[142]) begin
                eod_count++;
                rsp_pend_q.push_back(exp[141:133]);
                rsp_due_q.push_back(cycles + 1 + ($random(seed) & 15));
            end
        end
    endtask

    task automatic check_record();
        tx_bd_pkg::sn_t sn;
        rec_count++;
        if (rec_q.size() == 0) begin
            errors++;
            $display("kernel record at %0t ns with no response outstanding", $time);
        end else begin
            sn = rec_q.pop_front();
            check_value("kernel record", {exp_bd[sn], hacc_model[sn]}, kernel_bd_data);
        end
    endtask

    // ------------------------------------------------------------------------
    // monitors at mid-cycle and drivers 2 ns after the edge
    // ------------------------------------------------------------------------
    initial begin
        forever begin
            @(negedge clk_sys);
            if (!rst) begin
                if (desc_rd) take_descriptor();
                if (rd_cmd_wr) check_command();
                if (kernel_bd_wen) check_record();
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk_sys);
            #2;
            if (pop_pending) begin
                desc_q.delete(0);
                pop_pending = 1'b0;
            end
            desc_empty = (desc_q.size() == 0);
            desc_data  = desc_empty ? '0 : desc_q[0];
            if (ff_hold) rd_cmd_ff = 1'b1;
            else if (drive_random) rd_cmd_ff = (($random(seed) & 3) == 0);
            else rd_cmd_ff = 1'b0;
            if (drive_random) kernel_afull = (($random(seed) & 3) == 0);
            else kernel_afull = 1'b0;
            if (!rsp_hold && rsp_due_q.size() > 0 && rsp_due_q[0] <= cycles) begin
                rsp_wr = 1'b1;
                rsp_sn = rsp_pend_q.pop_front();
                rsp_due_q.delete(0);
                rec_q.push_back(rsp_sn);
            end else begin
                rsp_wr = 1'b0;
            end
        end
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("timeout after %0d cycles, the run hung waiting for the DUT", cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int start;
        int stretch;
        $timeformat(-9, 0, "", 0);
        seed = 80913;
        rst = 1'b1;
        desc_data = '0;
        desc_empty = 1'b1;
        rd_cmd_ff = 1'b0;
        hacc_wr = 1'b0;
        hacc_waddr = '0;
        hacc_wdata = '0;
        rsp_wr = 1'b0;
        rsp_sn = '0;
        kernel_afull = 1'b0;
        make_stimulus();
        repeat (2) @(posedge clk_sys);
        #2;
        rst = 1'b0;

        // accelerator RAM fill while outputs stay quiet
        for (int a = 0; a < 512; a++) begin
            @(posedge clk_sys);
            #2;
            hacc_wr = 1'b1;
            hacc_waddr = a;
            hacc_wdata = hacc_model[a];
            @(negedge clk_sys);
            check_value("desc_rd idle", 0, desc_rd);
            check_value("rd_cmd_wr idle", 0, rd_cmd_wr);
            check_value("kernel_bd_wen idle", 0, kernel_bd_wen);
        end
        @(posedge clk_sys);
        #2;
        hacc_wr = 1'b0;
        end_test("reset_idle");

        drive_random = 1'b1;
        load_descs(0, 24);
        while (rec_count < 24) @(negedge clk_sys);
        end_test("split_and_records");

        rsp_hold = 1'b1;
        load_descs(24, 8);
        while (eod_count < 28) @(negedge clk_sys);
        repeat (40) @(negedge clk_sys);
        check_value("reads with responses held", 28, desc_reads);
        rsp_hold = 1'b0;
        while (rec_count < 32) @(negedge clk_sys);
        check_value("reads after release", 32, desc_reads);
        end_test("inflight_limit");

        start = cmd_count;
        load_descs(32, 8);
        while (cmd_count == start) @(negedge clk_sys);
        #1;
        stretch = 20 + ($unsigned($random(seed)) % 40);
        ff_hold = 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        #1;
        start = cmd_count;      // last command before ff took effect
        repeat (stretch) @(negedge clk_sys);
        #1;
        check_value("commands while ff held", start, cmd_count);
        ff_hold = 1'b0;
        while (rec_count < 40) @(negedge clk_sys);
        check_value("commands left over", 0, exp_cmd_q.size());
        check_value("assertion failures", 0, dut_i.props_i.assert_fails);
        end_test("ff_hold");

        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tx_bd_props.sv */
// tx descriptor handler properties
`timescale 1ns/10ps
`default_nettype none

module tx_bd_props (
    input wire clk_sys,
    input wire rst,
    input wire desc_rd,
    input wire rd_cmd_wr,
    input wire rd_cmd_ff,
    input wire kernel_bd_wen
);

    int assert_fails = 0;

    desc_rd_gap: assert property (@(posedge clk_sys) disable iff (rst) desc_rd |=> !desc_rd)
        else begin assert_fails++; $error("desc_rd high in two consecutive cycles"); end

    cmd_gap: assert property (@(posedge clk_sys) disable iff (rst) rd_cmd_wr |=> !rd_cmd_wr)
        else begin assert_fails++; $error("rd_cmd_wr high in two consecutive cycles"); end

    cmd_after_ff: assert property (@(posedge clk_sys) disable iff (rst) rd_cmd_ff |=> !rd_cmd_wr)
        else begin assert_fails++; $error("read command issued after rd_cmd_ff was high"); end

    // no kernel write while in reset
    wen_in_reset: assert property (@(posedge clk_sys) rst |-> !kernel_bd_wen)
        else begin assert_fails++; $error("kernel_bd_wen high during reset"); end

endmodule

bind tx_bd_top tx_bd_props props_i (
    .clk_sys, .rst, .desc_rd, .rd_cmd_wr, .rd_cmd_ff, .kernel_bd_wen
);

`default_nettype wire

/* files.f */
src/tx_bd_pkg.sv
src/tx_bd_fmt_pkg.sv
src/dp_ram.sv
src/sn_fifo.sv
src/bd_fetch_ctrl.sv
src/rd_cmd_split.sv
src/kernel_bd_build.sv
src/tx_bd_top.sv
bench/tx_bd_props.sv
bench/tb_tx_bd.sv

/* src/bd_fetch_ctrl.sv */
// descriptor fetch control
`timescale 1ns/10ps
`default_nettype none

module bd_fetch_ctrl #(
    parameter int max_inflight = 450
) (
    input  wire                       clk_sys,
    input  wire                       rst,
    input  wire                       desc_empty,
    input  wire tx_bd_fmt_pkg::desc_t desc_data,
    input  wire                       rd_cmd_ff,
    input  wire                       rsp_afull,
    input  wire                       split_busy,
    input  wire                       rsp_pop,
    output logic                      desc_rd,
    output logic                      desc_take,
    output tx_bd_pkg::sn_t            cur_sn,
    output tx_bd_pkg::len_t           cur_len,
    output tx_bd_pkg::addr_t          cur_src,
    output tx_bd_pkg::acc_type_t      cur_acc_type,
    output tx_bd_pkg::ve_info_t       cur_ve_info,
    output logic                      bd_wr,
    output tx_bd_pkg::sn_t            bd_waddr,
    output tx_bd_fmt_pkg::bd_entry_t  bd_wdata
);

    localparam int cnt_w = $clog2(max_inflight + 1);

    logic [cnt_w-1:0] inflight;     // descriptors awaiting a response
    logic             fetch_en;
    tx_bd_pkg::sn_t   next_sn;
    tx_bd_pkg::addr_t cur_dst;

    assign fetch_en = !desc_empty && !rd_cmd_ff && !rsp_afull && !split_busy
                      && (inflight < cnt_w'(max_inflight)) && !desc_rd;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            desc_rd  <= 1'b0;
            bd_wr    <= 1'b0;
            next_sn  <= '0;
            inflight <= '0;
        end else begin
            desc_rd <= fetch_en;
            bd_wr   <= desc_rd;     // entry lands with the latched fields
            if (desc_rd) begin
                next_sn <= next_sn + 1'b1;  // wraps at 512
            end
            if (desc_rd && !rsp_pop) begin
                inflight <= inflight + 1'b1;
            end else if (!desc_rd && rsp_pop && (inflight != '0)) begin
                inflight <= inflight - 1'b1;
            end
        end
    end

    //--------------------------------------------------------------------------
    // field latch
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (desc_rd) begin
            cur_sn       <= next_sn;
            cur_acc_type <= desc_data[tx_bd_fmt_pkg::desc_acc_lsb +: 8];
            cur_ve_info  <= desc_data[tx_bd_fmt_pkg::desc_ve_lsb +: 48];
            cur_len      <= desc_data[tx_bd_fmt_pkg::desc_len_lsb +: 32];
            cur_dst      <= desc_data[tx_bd_fmt_pkg::desc_dst_lsb +: 64];
            cur_src      <= desc_data[tx_bd_fmt_pkg::desc_src_lsb +: 64];
        end
    end

    assign desc_take = desc_rd;
    assign bd_waddr  = cur_sn;
    assign bd_wdata  = {cur_len, cur_ve_info, cur_dst, cur_src};

endmodule

`default_nettype wire

/* src/dp_ram.sv */
// simple dual-port RAM
`timescale 1ns/10ps
`default_nettype none

module dp_ram #(
    parameter int width = 8,
    parameter int depth = 512
) (
    input  wire                     clk_sys,
    input  wire                     wr,
    input  wire [$clog2(depth)-1:0] waddr,
    input  wire [width-1:0]         wdata,
    input  wire [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]        rdata
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk_sys) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];    // one cycle after raddr
    end

endmodule

`default_nettype wire

/* src/kernel_bd_build.sv */
// kernel record builder
`timescale 1ns/10ps
`default_nettype none

module kernel_bd_build (
    input  wire                           clk_sys,
    input  wire                           rst,
    input  wire                           rsp_empty,
    input  wire tx_bd_pkg::sn_t           rsp_head,
    input  wire                           kernel_afull,
    input  wire tx_bd_fmt_pkg::bd_entry_t bd_rdata,
    input  wire tx_bd_pkg::hacc_t         hacc_rdata,
    output logic                          rsp_pop,
    output tx_bd_pkg::sn_t                bd_raddr,
    output tx_bd_pkg::sn_t                hacc_raddr,
    output logic                          kernel_bd_wen,
    output tx_bd_fmt_pkg::kbd_t           kernel_bd_data
);

    logic pop_d;    // RAM data valid

    // at most one pop every other cycle
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            rsp_pop       <= 1'b0;
            pop_d         <= 1'b0;
            kernel_bd_wen <= 1'b0;
        end else begin
            rsp_pop       <= !rsp_empty && !kernel_afull && !rsp_pop;
            pop_d         <= rsp_pop;
            kernel_bd_wen <= pop_d;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pop_d) begin
            kernel_bd_data <= {bd_rdata, hacc_rdata};
        end
    end

    // show-ahead head addresses both RAMs
    assign bd_raddr   = rsp_head;
    assign hacc_raddr = rsp_head;

endmodule

`default_nettype wire

/* src/rd_cmd_split.sv */
// read command splitter
`timescale 1ns/10ps
`default_nettype none

module rd_cmd_split (
    input  wire                       clk_sys,
    input  wire                       rst,
    input  wire                       desc_take,
    input  wire tx_bd_pkg::sn_t       cur_sn,
    input  wire tx_bd_pkg::len_t      cur_len,
    input  wire tx_bd_pkg::addr_t     cur_src,
    input  wire tx_bd_pkg::acc_type_t cur_acc_type,
    input  wire tx_bd_pkg::ve_info_t  cur_ve_info,
    input  wire                       rd_cmd_ff,
    output logic                      split_busy,
    output logic                      rd_cmd_wr,
    output logic                      rd_cmd_sod,
    output logic                      rd_cmd_eod,
    output tx_bd_pkg::sn_t            rd_cmd_sn,
    output tx_bd_pkg::chunk_len_t     rd_cmd_len,
    output tx_bd_pkg::addr_t          rd_cmd_addr,
    output tx_bd_pkg::acc_type_t      rd_cmd_acc_type,
    output tx_bd_pkg::ve_info_t       rd_cmd_ve_info
);

    tx_bd_pkg::split_state_t state;
    tx_bd_pkg::len_t         rem_len;
    tx_bd_pkg::addr_t        chunk_addr;
    tx_bd_pkg::chunk_len_t   chunk_len;
    logic                    take_d;        // latched fields valid
    logic                    first_chunk;
    logic                    last_chunk;
    logic                    emit;

    assign last_chunk = (rem_len <= tx_bd_pkg::len_t'(tx_bd_pkg::chunk_bytes));
    assign chunk_len  = last_chunk ? tx_bd_pkg::chunk_len_t'(rem_len)
                                   : tx_bd_pkg::chunk_len_t'(tx_bd_pkg::chunk_bytes);
    assign emit       = (state == tx_bd_pkg::issue) && !rd_cmd_ff;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            state       <= tx_bd_pkg::idle;
            take_d      <= 1'b0;
            split_busy  <= 1'b0;
            rd_cmd_wr   <= 1'b0;
            first_chunk <= 1'b0;
        end else begin
            take_d    <= desc_take;
            rd_cmd_wr <= emit;
            if (desc_take) begin
                split_busy <= 1'b1;
            end else if (rd_cmd_wr && rd_cmd_eod) begin
                split_busy <= 1'b0;
            end
            case (state)
                tx_bd_pkg::idle: begin
                    if (take_d) begin
                        state       <= tx_bd_pkg::issue;
                        first_chunk <= 1'b1;
                    end
                end
                tx_bd_pkg::issue: begin
                    if (emit) begin
                        state       <= last_chunk ? tx_bd_pkg::idle : tx_bd_pkg::wait_ff;
                        first_chunk <= 1'b0;
                    end
                end
                tx_bd_pkg::wait_ff: state <= tx_bd_pkg::issue;  // ff catches up with the write
                default:            state <= tx_bd_pkg::idle;
            endcase
        end
    end

    //--------------------------------------------------------------------------
    // chunk datapath
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if ((state == tx_bd_pkg::idle) && take_d) begin
            rem_len    <= cur_len;
            chunk_addr <= cur_src;
        end else if (emit) begin
            rem_len    <= rem_len - tx_bd_pkg::len_t'(tx_bd_pkg::chunk_bytes);
            chunk_addr <= chunk_addr + tx_bd_pkg::addr_t'(tx_bd_pkg::chunk_bytes);  // bits 63:12
        end
        if (emit) begin
            rd_cmd_sod      <= first_chunk;
            rd_cmd_eod      <= last_chunk;
            rd_cmd_len      <= chunk_len;
            rd_cmd_addr     <= chunk_addr;
            rd_cmd_sn       <= cur_sn;
            rd_cmd_acc_type <= cur_acc_type;
            rd_cmd_ve_info  <= cur_ve_info;
        end
    end

endmodule

`default_nettype wire

/* src/sn_fifo.sv */
// response serial number FIFO
`timescale 1ns/10ps
`default_nettype none

module sn_fifo #(
    parameter int rsp_depth       = 512,
    parameter int rsp_afull_level = 450
) (
    input  wire                 clk_sys,
    input  wire                 rst,
    input  wire                 wr,
    input  wire tx_bd_pkg::sn_t wdata,
    input  wire                 rd,
    output tx_bd_pkg::sn_t      rdata,
    output logic                empty,
    output logic                afull
);

    localparam int ptr_w = $clog2(rsp_depth);
    localparam int cnt_w = $clog2(rsp_depth + 1);

    tx_bd_pkg::sn_t   mem [rsp_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] level;
    logic             push;
    logic             pop;

    assign push = wr && (level != cnt_w'(rsp_depth));
    assign pop  = rd && !empty;

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(rsp_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(rsp_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                level <= level + 1'b1;
            end else if (pop && !push) begin
                level <= level - 1'b1;
            end
        end
    end

    assign rdata = mem[rd_ptr];     // head word shown ahead
    assign empty = (level == '0);
    assign afull = (level >= cnt_w'(rsp_afull_level));

endmodule

`default_nettype wire

/* src/tx_bd_fmt_pkg.sv */
// tx descriptor bit layouts
`default_nettype none

package tx_bd_fmt_pkg;

    //--------------------------------------------------------------------------
    // descriptor word, low to high: src, dst, len, ve info, access type
    //--------------------------------------------------------------------------
    localparam int desc_src_lsb = 0;
    localparam int desc_dst_lsb = desc_src_lsb + $bits(tx_bd_pkg::addr_t);
    localparam int desc_len_lsb = desc_dst_lsb + $bits(tx_bd_pkg::addr_t);
    localparam int desc_ve_lsb  = desc_len_lsb + $bits(tx_bd_pkg::len_t);
    localparam int desc_acc_lsb = desc_ve_lsb + $bits(tx_bd_pkg::ve_info_t);
    localparam int desc_w       = desc_acc_lsb + $bits(tx_bd_pkg::acc_type_t);  // 216

    typedef logic [desc_w-1:0] desc_t;

    // descriptor RAM entry {len, ve info, dst, src}
    localparam int bd_entry_w = $bits(tx_bd_pkg::len_t) + $bits(tx_bd_pkg::ve_info_t)
                              + 2 * $bits(tx_bd_pkg::addr_t);

    typedef logic [bd_entry_w-1:0] bd_entry_t;

    // kernel record, bd entry above accelerator entry
    localparam int kbd_w = bd_entry_w + $bits(tx_bd_pkg::hacc_t);

    typedef logic [kbd_w-1:0] kbd_t;

endpackage

`default_nettype wire

/* src/tx_bd_pkg.sv */
// tx descriptor common types
`default_nettype none

package tx_bd_pkg;

    // serial number also addresses both RAMs
    localparam int sn_w = 9;

    typedef logic [sn_w-1:0] sn_t;
    typedef logic [31:0]     len_t;
    typedef logic [12:0]     chunk_len_t;   // holds 4096 itself
    typedef logic [63:0]     addr_t;
    typedef logic [7:0]      acc_type_t;
    typedef logic [47:0]     ve_info_t;
    typedef logic [87:0]     hacc_t;        // accelerator entry

    // largest read command in bytes
    localparam int chunk_bytes = 4096;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_ff
    } split_state_t;

endpackage

`default_nettype wire

/* src/tx_bd_top.sv */
// tx descriptor handler top
`timescale 1ns/10ps
`default_nettype none

module tx_bd_top #(
    parameter int max_inflight    = 450,
    parameter int rsp_depth       = 512,
    parameter int rsp_afull_level = 450
) (
    input  wire                       clk_sys,
    input  wire                       rst,
    // descriptor FIFO
    output logic                      desc_rd,
    input  wire tx_bd_fmt_pkg::desc_t desc_data,
    input  wire                       desc_empty,
    // read commands
    output logic                      rd_cmd_wr,
    output logic                      rd_cmd_sod,
    output logic                      rd_cmd_eod,
    output tx_bd_pkg::sn_t            rd_cmd_sn,
    output tx_bd_pkg::chunk_len_t     rd_cmd_len,
    output tx_bd_pkg::addr_t          rd_cmd_addr,
    output tx_bd_pkg::acc_type_t      rd_cmd_acc_type,
    output tx_bd_pkg::ve_info_t       rd_cmd_ve_info,
    input  wire                       rd_cmd_ff,
    // accelerator RAM write
    input  wire                       hacc_wr,
    input  wire tx_bd_pkg::sn_t       hacc_waddr,
    input  wire tx_bd_pkg::hacc_t     hacc_wdata,
    // memory responses
    input  wire                       rsp_wr,
    input  wire tx_bd_pkg::sn_t       rsp_sn,
    // kernel
    input  wire                       kernel_afull,
    output logic                      kernel_bd_wen,
    output tx_bd_fmt_pkg::kbd_t       kernel_bd_data
);

    localparam int ram_depth = 2 ** tx_bd_pkg::sn_w;

    logic                      desc_take;
    tx_bd_pkg::sn_t            cur_sn;
    tx_bd_pkg::len_t           cur_len;
    tx_bd_pkg::addr_t          cur_src;
    tx_bd_pkg::acc_type_t      cur_acc_type;
    tx_bd_pkg::ve_info_t       cur_ve_info;
    logic                      split_busy;
    logic                      bd_wr;
    tx_bd_pkg::sn_t            bd_waddr;
    tx_bd_fmt_pkg::bd_entry_t  bd_wdata;
    tx_bd_pkg::sn_t            bd_raddr;
    tx_bd_fmt_pkg::bd_entry_t  bd_rdata;
    tx_bd_pkg::sn_t            hacc_raddr;
    tx_bd_pkg::hacc_t          hacc_rdata;
    logic                      rsp_empty;
    logic                      rsp_afull;
    logic                      rsp_pop;
    tx_bd_pkg::sn_t            rsp_head;

    //--------------------------------------------------------------------------
    // request side
    //--------------------------------------------------------------------------
    bd_fetch_ctrl #(.max_inflight(max_inflight)) bd_fetch_ctrl_i (
        .clk_sys, .rst, .desc_empty, .desc_data, .rd_cmd_ff, .rsp_afull, .split_busy,
        .rsp_pop, .desc_rd, .desc_take, .cur_sn, .cur_len, .cur_src, .cur_acc_type,
        .cur_ve_info, .bd_wr, .bd_waddr, .bd_wdata
    );

    rd_cmd_split rd_cmd_split_i (
        .clk_sys, .rst, .desc_take, .cur_sn, .cur_len, .cur_src, .cur_acc_type,
        .cur_ve_info, .rd_cmd_ff, .split_busy, .rd_cmd_wr, .rd_cmd_sod, .rd_cmd_eod,
        .rd_cmd_sn, .rd_cmd_len, .rd_cmd_addr, .rd_cmd_acc_type, .rd_cmd_ve_info
    );

    dp_ram #(.width($bits(tx_bd_fmt_pkg::bd_entry_t)), .depth(ram_depth)) bd_ram_i (
        .clk_sys, .wr(bd_wr), .waddr(bd_waddr), .wdata(bd_wdata),
        .raddr(bd_raddr), .rdata(bd_rdata)
    );

    //--------------------------------------------------------------------------
    // response side
    //--------------------------------------------------------------------------
    sn_fifo #(.rsp_depth(rsp_depth), .rsp_afull_level(rsp_afull_level)) sn_fifo_i (
        .clk_sys, .rst, .wr(rsp_wr), .wdata(rsp_sn), .rd(rsp_pop),
        .rdata(rsp_head), .empty(rsp_empty), .afull(rsp_afull)
    );

    dp_ram #(.width($bits(tx_bd_pkg::hacc_t)), .depth(ram_depth)) hacc_ram_i (
        .clk_sys, .wr(hacc_wr), .waddr(hacc_waddr), .wdata(hacc_wdata),
        .raddr(hacc_raddr), .rdata(hacc_rdata)
    );

    kernel_bd_build kernel_bd_build_i (
        .clk_sys, .rst, .rsp_empty, .rsp_head, .kernel_afull, .bd_rdata, .hacc_rdata,
        .rsp_pop, .bd_raddr, .hacc_raddr, .kernel_bd_wen, .kernel_bd_data
    );

endmodule

`default_nettype wire
